// ==== tb/cmt_vectors.txt ====
// Commit window lines in hex, bit n of the first four columns is slot n
// valid longop fls br pc0 pc1 pc2 pc3 opera taken prd prd_we latency result
// Plain groups
f 0 0 0 00000100 00000101 00000102 00000103 00000000 0 00 0 0 00000000
7 0 0 0 00000104 00000105 00000106 00000000 00000000 0 00 0 0 00000000
3 0 0 0 00000107 00000108 00000000 00000000 00000000 0 00 0 0 00000000
1 0 0 0 00000109 00000000 00000000 00000000 00000000 0 00 0 0 00000000
0 0 0 0 00000000 00000000 00000000 00000000 00000000 0 00 0 0 00000000
// Single-unit slots past slot 0 end the group
f 0 0 4 0000010a 0000010b 0000010c 0000010d 00000000 0 00 0 0 00000000
f 0 0 2 0000010b 0000010c 0000010d 0000010e 00000000 0 00 0 0 00000000
f 0 0 8 0000010c 0000010d 0000010e 0000010f 00000000 0 00 0 0 00000000
f 2 0 0 00000110 00000111 00000112 00000113 00000000 0 00 0 0 00000000
f 4 0 0 00000111 00000112 00000113 00000114 00000000 0 00 0 0 00000000
f 0 8 8 00000115 00000116 00000117 00000118 00000000 0 00 0 0 00000000
f 0 2 2 00000119 0000011a 0000011b 0000011c 00000000 0 00 0 0 00000000
// Slot 0 branches that were predicted correctly
f 0 0 1 00000200 00000201 00000202 00000203 00000280 1 00 0 0 00000000
3 0 0 1 00000210 00000211 00000000 00000000 00000211 0 00 0 0 00000000
f 0 0 3 00000220 00000221 00000222 00000223 00000240 1 00 0 0 00000000
1 0 0 1 3fffffff 00000000 00000000 00000000 00000000 0 00 0 0 00000000
// Slot 0 mispredicts, the next line meets the flush and is then repeated
1 0 1 1 00000300 00000000 00000000 00000000 00000380 0 00 0 0 00000000
f 0 0 0 00000380 00000381 00000382 00000383 00000000 0 00 0 0 00000000
f 0 0 0 00000380 00000381 00000382 00000383 00000000 0 00 0 0 00000000
1 0 1 1 00000400 00000000 00000000 00000000 00000401 1 00 0 0 00000000
0 0 0 0 00000000 00000000 00000000 00000000 00000000 0 00 0 0 00000000
1 0 1 1 00000500 00000000 00000000 00000000 3ffffff0 0 00 0 0 00000000
3 0 0 0 3ffffff0 3ffffff1 00000000 00000000 00000000 0 00 0 0 00000000
3 0 0 0 3ffffff0 3ffffff1 00000000 00000000 00000000 0 00 0 0 00000000
// Slot 0 long operations with varying latency
1 1 0 0 00000600 00000000 00000000 00000000 00000000 0 05 1 0 deadbeef
f 1 0 0 00000610 00000611 00000612 00000613 00000000 0 12 1 3 12345678
1 1 0 0 00000620 00000000 00000000 00000000 00000000 0 07 0 5 cafef00d
3 1 0 2 00000630 00000631 00000000 00000000 00000000 0 21 1 1 0badf00d
7 1 0 0 00000640 00000641 00000642 00000000 00000000 0 3f 1 2 ffffffff
// A long operation right behind a mispredict waits out the flush
1 0 1 1 00000700 00000000 00000000 00000000 00000740 0 00 0 0 00000000
1 1 0 0 00000740 00000000 00000000 00000000 00000000 0 0a 1 2 00c0ffee
f 0 0 0 00000741 00000742 00000743 00000744 00000000 0 00 0 0 00000000
// Mixed tail
f 0 0 4 00000800 00000801 00000802 00000803 00000000 0 00 0 0 00000000
3 0 0 1 00000802 00000803 00000000 00000000 00000803 0 00 0 0 00000000
1 1 0 0 00000804 00000000 00000000 00000000 00000000 0 01 1 4 a5a5a5a5
f 0 0 0 00000805 00000806 00000807 00000808 00000000 0 00 0 0 00000000

// ==== cmt.f ====
common/cmt_pkg.sv
hdl/cmt_fsm.sv
commit/cmt_window.sv
hdl/cmt_count.sv
hdl/cmt_top.sv
tb/cmt_checker.sv
tb/tb_cmt.sv

// ==== Makefile ====
SRCS := $(shell cat cmt.f)

obj_dir/Vtb_cmt: cmt.f $(SRCS)
	verilator --binary --timing --assert -Wno-fatal --top-module tb_cmt -f cmt.f -o Vtb_cmt

run: obj_dir/Vtb_cmt
	./obj_dir/Vtb_cmt | tee sim.log
	grep -q '\*\*\* TEST PASSED \*\*\*' sim.log

clean:
	rm -rf obj_dir sim.log

.PHONY: run clean

// ==== tb/tb_cmt.sv ====
// Vector lines carry exactly four slots, and every slot 0 long operation gets one done pulse
`timescale 1ns/1ps

module tb_cmt;
   import cmt_pkg::*;

   localparam int COMMIT_P_WIDTH = 2;
   localparam int CW             = 1 << COMMIT_P_WIDTH;
   localparam int FIELDS         = 14;   // Words per vector line
   localparam int MAX_VEC        = 64;
   localparam int CLK_NS         = 4;

   logic                    clk;
   logic                    rst_n;
   logic [CW-1:0]           cmt_valid;
   logic [CW-1:0]           cmt_longop;
   logic [CW-1:0]           cmt_fls;
   logic [CW-1:0]           cmt_br;
   pc_t [CW-1:0]            cmt_pc;
   pc_t                     cmt_opera;
   logic                    cmt_bpu_taken;
   prf_addr_t               cmt_prd;
   logic                    cmt_prd_we;
   logic                    longop_done;
   data_t                   longop_dout;
   logic                    longop_req;
   logic [CW-1:0]           cmt_fire;
   logic [COMMIT_P_WIDTH:0] cmt_pop_size;
   instret_t                instret;
   logic                    flush;
   pc_t                     flush_tgt;
   logic                    prf_we;
   prf_addr_t               prf_waddr;
   data_t                   prf_wdata;
   logic                    bpu_wb;
   logic                    bpu_wb_taken;
   pc_t                     bpu_wb_pc;
   pc_t                     bpu_wb_npc_act;

   logic [31:0] vec_mem [0:MAX_VEC*FIELDS-1];
   int          n_vec;
   int          max_lat;
   int          limit_ns;
   int          proto_errors = 0;
   int          cur_vec      = 0;
   bit          vectors_loaded = 1'b0;

   always #(CLK_NS/2) clk = ~clk;

   cmt_top #(.COMMIT_P_WIDTH(COMMIT_P_WIDTH)) uut (.*);

   cmt_checker #(.COMMIT_P_WIDTH(COMMIT_P_WIDTH)) u_chk (.vec_idx(cur_vec), .*);

   task automatic clear_inputs();
      begin
         cmt_valid     = '0;
         cmt_longop    = '0;
         cmt_fls       = '0;
         cmt_br        = '0;
         cmt_pc        = '0;
         cmt_opera     = '0;
         cmt_bpu_taken = 1'b0;
         cmt_prd       = '0;
         cmt_prd_we    = 1'b0;
         longop_done   = 1'b0;
         longop_dout   = '0;
      end
   endtask

   task automatic apply_vector(input int v);
      int b;
      int s;
      begin
         b             = v * FIELDS;
         cur_vec       = v;
         cmt_valid     = vec_mem[b][CW-1:0];
         cmt_longop    = vec_mem[b+1][CW-1:0];
         cmt_fls       = vec_mem[b+2][CW-1:0];
         cmt_br        = vec_mem[b+3][CW-1:0];
         for (s = 0; s < CW; s++)
            cmt_pc[s] = vec_mem[b+4+s][PC_W-1:0];
         cmt_opera     = vec_mem[b+8][PC_W-1:0];
         cmt_bpu_taken = vec_mem[b+9][0];
         cmt_prd       = vec_mem[b+10][PRF_AW-1:0];
         cmt_prd_we    = vec_mem[b+11][0];
      end
   endtask

   // Holds the line until the outside unit has answered the request
   task automatic serve_longop(input int v);
      int tries;
      bit seen;
      begin
         tries = 0;
         seen  = 1'b0;
         while (!seen && tries < 3)   // A flush cycle may delay the request
         begin
            @(negedge clk);
            seen = longop_req;
            tries++;
         end
         if (seen)
         begin
            @(posedge clk);
            repeat (int'(vec_mem[v*FIELDS+12])) @(posedge clk);
            #1;
            longop_done = 1'b1;
            longop_dout = vec_mem[v*FIELDS+13];
            @(posedge clk);
            #1;
            longop_done = 1'b0;
         end
         else
         begin
            proto_errors++;
            $display("Vector %0d: longop_req never rose for the slot 0 long operation", v);
            @(posedge clk);
            #1;
         end
      end
   endtask

   initial
   begin
      int i;
      int v;
      clk   = 1'b0;
      rst_n = 1'b0;
      clear_inputs();
      for (i = 0; i < MAX_VEC*FIELDS; i++)
         vec_mem[i] = '1;   // End marker where the file stops
      $readmemh("tb/cmt_vectors.txt", vec_mem);
      n_vec   = 0;
      max_lat = 0;
      while (n_vec < MAX_VEC && vec_mem[n_vec*FIELDS] != 32'hFFFF_FFFF)
      begin
         if (int'(vec_mem[n_vec*FIELDS+12]) > max_lat)
            max_lat = int'(vec_mem[n_vec*FIELDS+12]);
         n_vec++;
      end
      if (n_vec == 0)
      begin
         proto_errors++;
         $display("No vectors were read from tb/cmt_vectors.txt");
      end
      limit_ns       = (n_vec * (max_lat + 3) + 8) * CLK_NS;   // Reset and drain included
      vectors_loaded = 1'b1;

      repeat (4) @(posedge clk);
      #1;
      rst_n = 1'b1;
      for (v = 0; v < n_vec; v++)
      begin
         apply_vector(v);
         if (cmt_valid[0] && cmt_longop[0])
            serve_longop(v);
         else
         begin
            @(posedge clk);
            #1;
         end
      end
      clear_inputs();
      repeat (3) @(posedge clk);   // Let the last counts settle
      @(negedge clk);
      $display("Summary: %0d checks, %0d value errors, %0d other errors",
               u_chk.check_count, u_chk.err_count, proto_errors);
      if (u_chk.err_count == 0 && proto_errors == 0)
         $display("*** TEST PASSED ***");
      else
         $display("*** TEST FAILED ***");
      $finish;
   end

   // Watchdog
   initial
   begin
      wait (vectors_loaded);
      #(limit_ns);
      $display("Timeout: the run did not finish within %0d ns", limit_ns);
      $display("*** TEST FAILED ***");
      $finish;
   end

endmodule

// ==== tb/cmt_checker.sv ====
// Samples on the falling clock edge, so the DUT inputs must change only after the rising edge
`timescale 1ns/1ps

module cmt_checker
#(
   parameter  int COMMIT_P_WIDTH = 2,
   localparam int CW             = 1 << COMMIT_P_WIDTH
)
(
   input logic                       clk,
   input logic                       rst_n,
   input int                         vec_idx,
   input logic [CW-1:0]              cmt_valid,
   input logic [CW-1:0]              cmt_longop,
   input logic [CW-1:0]              cmt_fls,
   input logic [CW-1:0]              cmt_br,
   input cmt_pkg::pc_t [CW-1:0]      cmt_pc,
   input cmt_pkg::pc_t               cmt_opera,
   input logic                       cmt_bpu_taken,
   input cmt_pkg::prf_addr_t         cmt_prd,
   input logic                       cmt_prd_we,
   input logic                       longop_done,
   input cmt_pkg::data_t             longop_dout,
   input logic                       longop_req,
   input logic [CW-1:0]              cmt_fire,
   input logic [COMMIT_P_WIDTH:0]    cmt_pop_size,
   input cmt_pkg::instret_t          instret,
   input logic                       flush,
   input cmt_pkg::pc_t               flush_tgt,
   input logic                       prf_we,
   input cmt_pkg::prf_addr_t         prf_waddr,
   input cmt_pkg::data_t             prf_wdata,
   input logic                       bpu_wb,
   input logic                       bpu_wb_taken,
   input cmt_pkg::pc_t               bpu_wb_pc,
   input cmt_pkg::pc_t               bpu_wb_npc_act
);
   import cmt_pkg::*;

   int       err_count   = 0;
   int       check_count = 0;
   bit       flush_m;     // Redirect expected in this cycle
   bit       pending_m;   // Long operation handed out, no done yet
   pc_t      tgt_m;       // Target of the last slot 0 that retired
   instret_t instret_m;   // Running sum of expected pop sizes

   task automatic compare(input string name, input logic [63:0] expected,
                          input logic [63:0] actual);
      begin
         check_count++;
         if (expected !== actual)
         begin
            err_count++;
            $display("[FAIL] %s (vector %0d) expected %h actual %h",
                     name, vec_idx, expected, actual);
         end
      end
   endtask

   always @(negedge clk)
   begin
      logic [CW-1:0]           fire_exp;
      logic [COMMIT_P_WIDTH:0] pop_exp;
      logic                    pend;
      logic                    stop;
      logic                    wb_exp;
      logic                    we_exp;
      logic                    taken_exp;
      pc_t                     npc_exp;
      int                      j;
      if (!rst_n)
      begin
         flush_m   = 1'b0;
         pending_m = 1'b0;
         instret_m = '0;
      end
      else
      begin
         pend = cmt_valid[0] & cmt_longop[0] & ~flush_m;
         // Walk the window from the oldest slot until the group has to end
         stop = flush_m | (pend & ~longop_done);
         fire_exp = '0;
         for (j = 0; j < CW; j++)
         begin
            if (j > 0 && (cmt_longop[j] | cmt_fls[j] | cmt_br[j]))
               stop = 1'b1;   // Single-unit slot waits for the next group
            if (!stop)
               fire_exp[j] = cmt_valid[j];
         end
         pop_exp = (COMMIT_P_WIDTH+1)'($countones(fire_exp));
         wb_exp  = fire_exp[0] & cmt_br[0];
         we_exp  = longop_done & ~flush_m & cmt_prd_we;

         // Real direction is the guess, turned around when it was wrong
         taken_exp = cmt_fls[0] ? ~cmt_bpu_taken : cmt_bpu_taken;
         npc_exp   = cmt_pc[0] + pc_t'(1);   // Wraps at the PC width
         if (cmt_fls[0])
            npc_exp = cmt_opera;

         compare("group_fire", 64'(fire_exp), 64'(cmt_fire));
         compare("pop_size", 64'(pop_exp), 64'(cmt_pop_size));
         compare("instret", 64'(instret_m), 64'(instret));
         compare("flush", 64'(flush_m), 64'(flush));
         if (flush_m)
            compare("flush_tgt", 64'(tgt_m), 64'(flush_tgt));
         compare("longop_req", 64'(~pending_m & pend), 64'(longop_req));
         compare("bpu_wb", 64'(wb_exp), 64'(bpu_wb));
         if (wb_exp)
         begin
            compare("bpu_wb_taken", 64'(taken_exp), 64'(bpu_wb_taken));
            compare("bpu_wb_pc", 64'(cmt_pc[0]), 64'(bpu_wb_pc));
            compare("bpu_wb_npc_act", 64'(npc_exp), 64'(bpu_wb_npc_act));
         end
         compare("prf_we", 64'(we_exp), 64'(prf_we));
         if (we_exp)
         begin
            compare("prf_waddr", 64'(cmt_prd), 64'(prf_waddr));
            compare("prf_wdata", 64'(longop_dout), 64'(prf_wdata));
         end

         // State seen after the coming rising edge
         flush_m = fire_exp[0] & cmt_fls[0];
         if (fire_exp[0])
            tgt_m = cmt_opera;
         if (!pending_m && pend)
            pending_m = 1'b1;
         else if (pending_m && longop_done)
            pending_m = 1'b0;
         instret_m = instret_m + instret_t'(pop_exp);
      end
   end

endmodule

// ==== hdl/cmt_top.sv ====
// The outside unit must hold all slot inputs steady while a long operation is pending
`timescale 1ns/1ps

module cmt_top
#(
   parameter  int COMMIT_P_WIDTH = 2,   // Log2 of the window, 1 to 3
   localparam int CW             = 1 << COMMIT_P_WIDTH
)
(
   input  logic                       clk,
   input  logic                       rst_n,
   // Commit window, slot 0 oldest
   input  logic [CW-1:0]              cmt_valid,
   input  logic [CW-1:0]              cmt_longop,
   input  logic [CW-1:0]              cmt_fls,
   input  logic [CW-1:0]              cmt_br,
   input  cmt_pkg::pc_t [CW-1:0]      cmt_pc,
   // Slot 0 only
   input  cmt_pkg::pc_t               cmt_opera,
   input  logic                       cmt_bpu_taken,
   input  cmt_pkg::prf_addr_t         cmt_prd,
   input  logic                       cmt_prd_we,
   // Outside long-operation unit
   input  logic                       longop_done,
   input  cmt_pkg::data_t             longop_dout,
   output logic                       longop_req,
   // To ROB
   output logic [CW-1:0]              cmt_fire,
   output logic [COMMIT_P_WIDTH:0]    cmt_pop_size,
   output cmt_pkg::instret_t          instret,
   // Redirect to fetch
   output logic                       flush,
   output cmt_pkg::pc_t               flush_tgt,
   // Register file write port
   output logic                       prf_we,
   output cmt_pkg::prf_addr_t         prf_waddr,
   output cmt_pkg::data_t             prf_wdata,
   // Predictor update
   output logic                       bpu_wb,
   output logic                       bpu_wb_taken,
   output cmt_pkg::pc_t               bpu_wb_pc,
   output cmt_pkg::pc_t               bpu_wb_npc_act
);

   logic longop_pend;   // Window to FSM
   logic cmt_ce;        // FSM back to window

   cmt_fsm u_fsm
   (
      .clk          (clk),
      .rst_n        (rst_n),
      .longop_pend  (longop_pend),
      .longop_done  (longop_done),
      .longop_req   (longop_req),
      .cmt_ce       (cmt_ce)
   );

   cmt_window
   #(
      .COMMIT_P_WIDTH (COMMIT_P_WIDTH)
   )
   u_window
   (
      .clk            (clk),
      .rst_n          (rst_n),
      .cmt_ce         (cmt_ce),
      .cmt_valid      (cmt_valid),
      .cmt_longop     (cmt_longop),
      .cmt_fls        (cmt_fls),
      .cmt_br         (cmt_br),
      .cmt_pc         (cmt_pc),
      .cmt_opera      (cmt_opera),
      .cmt_bpu_taken  (cmt_bpu_taken),
      .cmt_prd        (cmt_prd),
      .cmt_prd_we     (cmt_prd_we),
      .longop_done    (longop_done),
      .longop_dout    (longop_dout),
      .longop_pend    (longop_pend),
      .cmt_fire       (cmt_fire),
      .flush          (flush),
      .flush_tgt      (flush_tgt),
      .prf_we         (prf_we),
      .prf_waddr      (prf_waddr),
      .prf_wdata      (prf_wdata),
      .bpu_wb         (bpu_wb),
      .bpu_wb_taken   (bpu_wb_taken),
      .bpu_wb_pc      (bpu_wb_pc),
      .bpu_wb_npc_act (bpu_wb_npc_act)
   );

   cmt_count
   #(
      .COMMIT_P_WIDTH (COMMIT_P_WIDTH)
   )
   u_count
   (
      .clk          (clk),
      .rst_n        (rst_n),
      .cmt_fire     (cmt_fire),
      .cmt_pop_size (cmt_pop_size),
      .instret      (instret)
   );

endmodule

// ==== hdl/cmt_count.sv ====
// The retired count wraps silently at INSTRET_W bits
`timescale 1ns/1ps

module cmt_count
#(
   parameter  int COMMIT_P_WIDTH = 2,
   localparam int CW             = 1 << COMMIT_P_WIDTH
)
(
   input  logic                    clk,
   input  logic                    rst_n,
   input  logic [CW-1:0]           cmt_fire,
   output logic [COMMIT_P_WIDTH:0] cmt_pop_size,   // Retired this cycle
   output cmt_pkg::instret_t       instret         // Retired since reset
);
   import cmt_pkg::*;

   // Population count of the fire vector
   always_comb
   begin
      cmt_pop_size = '0;
      for (int i = 0; i < CW; i++)
         cmt_pop_size = cmt_pop_size + {{COMMIT_P_WIDTH{1'b0}}, cmt_fire[i]};
   end

   always_ff @(posedge clk)
   begin
      if (!rst_n)
         instret <= '0;
      else
         instret <= instret + instret_t'(cmt_pop_size);
   end

   // Each edge adds exactly what retired in the cycle before
   a_instret_step: assert property (
      @(posedge clk) disable iff (!rst_n)
      1'b1 |=> (instret == instret_t'($past(instret) + instret_t'($past(cmt_pop_size))))
   ) else $error("instret stepped by something other than the pop size");

endmodule

// ==== commit/cmt_window.sv ====
// Slot 0 is the oldest slot and the ROB keeps the valid slots contiguous from slot 0
`timescale 1ns/1ps

module cmt_window
#(
   parameter  int COMMIT_P_WIDTH = 2,
   localparam int CW             = 1 << COMMIT_P_WIDTH
)
(
   input  logic                       clk,
   input  logic                       rst_n,
   input  logic                       cmt_ce,
   input  logic [CW-1:0]              cmt_valid,
   input  logic [CW-1:0]              cmt_longop,
   input  logic [CW-1:0]              cmt_fls,        // Mispredicted
   input  logic [CW-1:0]              cmt_br,         // Is a branch
   input  cmt_pkg::pc_t [CW-1:0]      cmt_pc,
   input  cmt_pkg::pc_t               cmt_opera,      // Slot 0 actual target
   input  logic                       cmt_bpu_taken,  // Slot 0 predicted direction
   input  cmt_pkg::prf_addr_t         cmt_prd,
   input  logic                       cmt_prd_we,
   input  logic                       longop_done,
   input  cmt_pkg::data_t             longop_dout,
   output logic                       longop_pend,
   output logic [CW-1:0]              cmt_fire,
   output logic                       flush,
   output cmt_pkg::pc_t               flush_tgt,
   output logic                       prf_we,
   output cmt_pkg::prf_addr_t         prf_waddr,
   output cmt_pkg::data_t             prf_wdata,
   output logic                       bpu_wb,
   output logic                       bpu_wb_taken,
   output cmt_pkg::pc_t               bpu_wb_pc,
   output cmt_pkg::pc_t               bpu_wb_npc_act
);
   import cmt_pkg::*;

   logic [CW-1:0] single_unit;
   logic [CW-1:0] cmt_mask;
   logic          flush_q;
   pc_t           flush_tgt_q;
   pc_t           npc_0;

   // These slots must retire without any younger slot ahead of them
   assign single_unit = cmt_longop | cmt_fls | cmt_br;

   // The FSM only sees slot 0, and never during a flush cycle
   assign longop_pend = cmt_valid[0] & cmt_longop[0] & ~flush;

   // Group ends right before the first single-unit slot past slot 0
   always_comb
   begin
      cmt_mask[0] = cmt_ce & ~flush;
      for (int j = 1; j < CW; j++)
         cmt_mask[j] = cmt_mask[j-1] & ~single_unit[j];
   end

   assign cmt_fire = cmt_valid & cmt_mask;

   // Loaded every cycle so the flush is a single pulse
   always_ff @(posedge clk)
   begin
      if (!rst_n)
         flush_q <= 1'b0;
      else
         flush_q <= cmt_fire[0] & cmt_fls[0];
   end

   always_ff @(posedge clk)
   begin
      if (cmt_fire[0])
         flush_tgt_q <= cmt_opera;   // Redirect target of the retiring slot
   end

   assign flush     = flush_q;
   assign flush_tgt = flush_tgt_q;

   // Fall-through address of slot 0
   assign npc_0 = cmt_pc[0] + pc_t'(1);

   assign bpu_wb         = cmt_fire[0] & cmt_br[0];
   assign bpu_wb_taken   = cmt_bpu_taken ^ cmt_fls[0];   // Flip a wrong guess
   assign bpu_wb_pc      = cmt_pc[0];
   assign bpu_wb_npc_act = cmt_fls[0] ? cmt_opera : npc_0;

   // Result of the long operation goes straight to the register file
   assign prf_we    = longop_done & ~flush & cmt_prd_we;
   assign prf_waddr = cmt_prd;
   assign prf_wdata = longop_dout;

   // A retired mispredict blocks the next cycle and then releases it
   a_flush_after_mispredict: assert property (
      @(posedge clk) disable iff (!rst_n)
      (cmt_fire[0] && cmt_fls[0]) |=> (flush && (cmt_fire == '0))
   ) else $error("mispredict did not produce a quiet flush cycle");

   a_flush_one_cycle: assert property (
      @(posedge clk) disable iff (!rst_n)
      flush |=> !flush
   ) else $error("flush held for more than one cycle");

   // Younger slots never retire past an older valid slot
   for (genvar k = 1; k < CW; k++)
   begin : g_order
      a_in_order: assert property (
         @(posedge clk) disable iff (!rst_n)
         cmt_fire[k] |-> ((cmt_valid[k-1:0] & ~cmt_fire[k-1:0]) == '0)
      ) else $error("slot %0d fired ahead of an older valid slot", k);
   end

endmodule

// ==== hdl/cmt_fsm.sv ====
// The outside unit must answer each longop_req with exactly one longop_done pulse
`timescale 1ns/1ps

module cmt_fsm
(
   input  logic clk,
   input  logic rst_n,
   input  logic longop_pend,   // Slot 0 holds a long operation
   input  logic longop_done,   // Completion pulse from the outside unit
   output logic longop_req,    // Start strobe to the outside unit
   output logic cmt_ce         // Commit enable for the window
);
   import cmt_pkg::*;

   cmt_state_t state_q;
   cmt_state_t state_nxt;

   always_comb
   begin
      state_nxt = state_q;
      case (state_q)
         S_IDLE:
         begin
            if (longop_pend)
               state_nxt = S_PENDING;   // Request goes out this cycle
         end
         S_PENDING:
         begin
            if (longop_done)
               state_nxt = S_IDLE;      // Slot 0 retires with the result
         end
         default:
            state_nxt = S_IDLE;
      endcase
   end

   always_ff @(posedge clk)
   begin
      if (!rst_n)
         state_q <= S_IDLE;
      else
         state_q <= state_nxt;
   end

   // Single-cycle strobe, only when the unit is not yet busy
   assign longop_req = (state_q == S_IDLE) & longop_pend;

   // Hold the whole window until the result is back
   assign cmt_ce = ~longop_pend | longop_done;

   // The outside unit never completes something that was not requested
   a_no_done_in_idle: assert property (
      @(posedge clk) disable iff (!rst_n)
      (state_q == S_IDLE) |-> !longop_done
   ) else $error("longop_done seen while no long operation was pending");

endmodule

// ==== common/cmt_pkg.sv ====
// PC values are word addresses, so a PC step of one is one 32-bit instruction
package cmt_pkg;

   // Program counter without the two byte-offset bits
   localparam int PC_W      = 30;

   // Operand and result word
   localparam int DW        = 32;

   // Physical register file address
   localparam int PRF_AW    = 6;

   // Retired-instruction counter, wraps at this width
   localparam int INSTRET_W = 32;

   typedef logic [PC_W-1:0]      pc_t;       // PCs and branch targets
   typedef logic [DW-1:0]        data_t;     // Long-operation result
   typedef logic [PRF_AW-1:0]    prf_addr_t; // Destination register number
   typedef logic [INSTRET_W-1:0] instret_t;  // Retired count

   // Long-operation handshake with the outside unit.
   // One-hot so each state is a single flop bit.
   typedef enum logic [1:0]
   {
      S_IDLE    = 2'b01,  // No long operation in flight
      S_PENDING = 2'b10   // Waiting for the done pulse
   } cmt_state_t;

endpackage
